// ==== hdl/rv32i_types.sv ====
package rv32i_types;

    // data and address widths
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    localparam addr_t RESET_PC = 32'h6000_0000;  // first fetch after reset

    // instruction memory, word addressed by pc[9:2]
    localparam int IMEM_AW    = 8;
    localparam int IMEM_DEPTH = 1 << IMEM_AW;

    typedef logic [IMEM_AW-1:0] imem_addr_t;

    // instruction queue
    localparam int QPTR_W      = 3;
    localparam int QUEUE_DEPTH = 1 << QPTR_W;   // must stay a power of two

    typedef logic [QPTR_W:0] qcount_t;          // one extra bit so full fits

    // opcodes seen by predecode
    typedef logic [6:0] opcode_t;

    localparam opcode_t OPC_JAL  = 7'b1101111;
    localparam opcode_t OPC_JALR = 7'b1100111;

    // predecode FSM
    typedef enum logic
    {
        PD_RUN,
        PD_JALR_WAIT   // fetch stalled until jalr target known
    } pd_state_t;

endpackage

// ==== hdl/fetch_if.sv ====
`timescale 1ns/1ns

// one fetched entry, fetch stage output
interface fetch_if;

    logic               valid;
    rv32i_types::addr_t pc;     // pc of the fetched word
    rv32i_types::word_t inst;

    // fetch_mem side
    modport producer
    (
        output valid,
        output pc,
        output inst
    );

    // predecode and inst_queue side
    modport consumer
    (
        input valid,
        input pc,
        input inst
    );

endinterface

// ==== hdl/pc_reg.sv ====
`timescale 1ns/1ns

module pc_reg
(
    input  logic               clk,
    input  logic               rst,
    input  logic               request_new_inst,
    input  logic               br_en,
    input  logic               flush,
    input  logic               branch_recovery,
    input  logic               jump_en,
    input  logic               jalr_done,
    input  rv32i_types::addr_t pc_branch,
    input  rv32i_types::addr_t missed_pc,
    input  rv32i_types::addr_t brr_pc,
    input  rv32i_types::addr_t pc_jump,
    input  rv32i_types::addr_t jalr_pc,
    output rv32i_types::addr_t pc
);

    rv32i_types::addr_t pc_held;
    rv32i_types::addr_t pc_next;
    logic               held_fetched;  // pc_held already read from memory
    logic               ext_redirect;
    logic               redirect;
    logic               load;

    assign ext_redirect = br_en | flush | branch_recovery;
    assign redirect     = ext_redirect | jump_en | jalr_done;
    assign load         = request_new_inst | redirect;

    // fixed priority, external redirects first
    always_comb
    begin
        if (br_en)
            pc_next = pc_branch;
        else if (flush)
            pc_next = missed_pc;
        else if (branch_recovery)
            pc_next = brr_pc;
        else if (jump_en)
            pc_next = pc_jump;
        else if (jalr_done)
            pc_next = jalr_pc;
        else if (held_fetched)
            pc_next = pc_held + 32'd4;
        else
            pc_next = pc_held;  // target loaded but not read yet
    end

    // redirect target goes out in its own cycle
    assign pc = load ? pc_next : pc_held;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc_held      <= rv32i_types::RESET_PC;
            held_fetched <= 1'b0;
        end
        else if (load)
        begin
            pc_held <= pc_next;
            // a read in a kill cycle is dropped by fetch_mem, so it is redone
            held_fetched <= request_new_inst & ~ext_redirect;
        end
    end

endmodule

// ==== hdl/fetch_mem.sv ====
`timescale 1ns/1ns

module fetch_mem
(
    input  logic                    clk,
    input  logic                    rst,
    input  rv32i_types::addr_t      pc,
    input  logic                    request_new_inst,
    input  logic                    kill,
    input  logic                    imem_we,
    input  rv32i_types::imem_addr_t imem_waddr,
    input  rv32i_types::word_t      imem_wdata,
    fetch_if.producer               fe
);

    rv32i_types::word_t      mem [rv32i_types::IMEM_DEPTH];
    rv32i_types::imem_addr_t raddr;

    // word index from pc, upper bits ignored so fetch wraps
    assign raddr = pc[rv32i_types::IMEM_AW+1:2];

    // load port
    always_ff @(posedge clk)
    begin
        if (imem_we)
            mem[imem_waddr] <= imem_wdata;
    end

    // registered read, entry payload
    always_ff @(posedge clk)
    begin
        if (request_new_inst)
        begin
            fe.inst <= mem[raddr];
            fe.pc   <= pc;
        end
    end

    // stage valid bit
    always_ff @(posedge clk)
    begin
        if (rst)
            fe.valid <= 1'b0;
        else if (kill)
            fe.valid <= 1'b0;   // wrong path, drop it
        else
            fe.valid <= request_new_inst;
    end

endmodule

// ==== hdl/predecode.sv ====
`timescale 1ns/1ns

module predecode
(
    input  logic               clk,
    input  logic               rst,
    fetch_if.consumer          fe,
    input  logic               space_ok,
    input  logic               jalr_done,
    input  logic               ext_redirect,
    output logic               jump_en,
    output rv32i_types::addr_t pc_jump,
    output logic               request_new_inst
);

    rv32i_types::pd_state_t state;
    rv32i_types::pd_state_t state_next;
    rv32i_types::opcode_t   opcode;
    rv32i_types::addr_t     j_imm;
    logic                   is_jal;
    logic                   is_jalr;

    assign opcode  = fe.inst[6:0];
    assign is_jal  = fe.valid && (opcode == rv32i_types::OPC_JAL);
    assign is_jalr = fe.valid && (opcode == rv32i_types::OPC_JALR);

    // J-type immediate, sign extended
    assign j_imm = {{12{fe.inst[31]}}, fe.inst[19:12], fe.inst[20], fe.inst[30:21], 1'b0};

    assign jump_en = is_jal;
    assign pc_jump = fe.pc + j_imm;

    always_comb
    begin
        state_next = state;
        case (state)
            rv32i_types::PD_RUN:
            begin
                if (is_jalr && !ext_redirect)
                    state_next = rv32i_types::PD_JALR_WAIT;
            end
            rv32i_types::PD_JALR_WAIT:
            begin
                if (jalr_done || ext_redirect)
                    state_next = rv32i_types::PD_RUN;
            end
            default:
                state_next = rv32i_types::PD_RUN;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= rv32i_types::PD_RUN;
        else
            state <= state_next;
    end

    // no fetch past a jalr, or into a full queue
    assign request_new_inst = (state == rv32i_types::PD_RUN) && space_ok && !is_jalr;

endmodule

// ==== hdl/inst_queue.sv ====
`timescale 1ns/1ns

module inst_queue
(
    input  logic               clk,
    input  logic               rst,
    fetch_if.consumer          fe,
    input  logic               clear,
    input  logic               deq,
    output logic               space_ok,
    output logic               out_valid,
    output rv32i_types::addr_t out_pc,
    output rv32i_types::word_t out_inst
);

    rv32i_types::addr_t              pc_q   [rv32i_types::QUEUE_DEPTH];
    rv32i_types::word_t              inst_q [rv32i_types::QUEUE_DEPTH];
    logic [rv32i_types::QPTR_W-1:0]  wptr;
    logic [rv32i_types::QPTR_W-1:0]  rptr;
    rv32i_types::qcount_t            count;
    rv32i_types::qcount_t            occupancy;  // stored plus in flight
    logic                            enq;
    logic                            pop;

    assign enq = fe.valid & ~clear;   // clear wins over a wrong-path entry
    assign pop = deq & out_valid;

    assign out_valid = (count != '0);
    assign out_pc    = pc_q[rptr];
    assign out_inst  = inst_q[rptr];

    // the fetch stage entry lands next edge, so reserve a slot for it
    assign occupancy = count + {{rv32i_types::QPTR_W{1'b0}}, fe.valid};
    assign space_ok  = occupancy < rv32i_types::qcount_t'(rv32i_types::QUEUE_DEPTH);

    // entry storage
    always_ff @(posedge clk)
    begin
        if (enq)
        begin
            pc_q[wptr]   <= fe.pc;
            inst_q[wptr] <= fe.inst;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk)
    begin
        if (rst || clear)
        begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end
        else
        begin
            if (enq)
                wptr <= wptr + 1'b1;
            if (pop)
                rptr <= rptr + 1'b1;
            case ({enq, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== hdl/fetch_top.sv ====
`timescale 1ns/1ns

module fetch_top
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    br_en,
    input  logic                    flush,
    input  logic                    branch_recovery,
    input  logic                    jalr_done,
    input  logic                    deq,
    input  logic                    imem_we,
    input  rv32i_types::addr_t      pc_branch,
    input  rv32i_types::addr_t      missed_pc,
    input  rv32i_types::addr_t      brr_pc,
    input  rv32i_types::addr_t      jalr_pc,
    input  rv32i_types::imem_addr_t imem_waddr,
    input  rv32i_types::word_t      imem_wdata,
    output logic                    out_valid,
    output rv32i_types::addr_t      out_pc,
    output rv32i_types::word_t      out_inst
);

    rv32i_types::addr_t pc;
    rv32i_types::addr_t pc_jump;
    logic               request_new_inst;
    logic               jump_en;
    logic               space_ok;
    logic               ext_redirect;

    fetch_if fe_bus ();

    // any backend redirect kills the fetch stage and empties the queue
    assign ext_redirect = br_en | flush | branch_recovery;

    pc_reg u_pc_reg
    (
        .clk              (clk),
        .rst              (rst),
        .request_new_inst (request_new_inst),
        .br_en            (br_en),
        .flush            (flush),
        .branch_recovery  (branch_recovery),
        .jump_en          (jump_en),
        .jalr_done        (jalr_done),
        .pc_branch        (pc_branch),
        .missed_pc        (missed_pc),
        .brr_pc           (brr_pc),
        .pc_jump          (pc_jump),
        .jalr_pc          (jalr_pc),
        .pc               (pc)
    );

    fetch_mem u_fetch_mem
    (
        .clk              (clk),
        .rst              (rst),
        .pc               (pc),
        .request_new_inst (request_new_inst),
        .kill             (ext_redirect),
        .imem_we          (imem_we),
        .imem_waddr       (imem_waddr),
        .imem_wdata       (imem_wdata),
        .fe               (fe_bus.producer)
    );

    predecode u_predecode
    (
        .clk              (clk),
        .rst              (rst),
        .fe               (fe_bus.consumer),
        .space_ok         (space_ok),
        .jalr_done        (jalr_done),
        .ext_redirect     (ext_redirect),
        .jump_en          (jump_en),
        .pc_jump          (pc_jump),
        .request_new_inst (request_new_inst)
    );

    inst_queue u_inst_queue
    (
        .clk       (clk),
        .rst       (rst),
        .fe        (fe_bus.consumer),
        .clear     (ext_redirect),
        .deq       (deq),
        .space_ok  (space_ok),
        .out_valid (out_valid),
        .out_pc    (out_pc),
        .out_inst  (out_inst)
    );

endmodule

// ==== dv/fetch_props.sv ====
`timescale 1ns/1ns

module fetch_props
(
    input logic                   clk,
    input logic                   rst,
    input rv32i_types::qcount_t   count,
    input logic                   clear,
    input logic                   out_valid,
    input rv32i_types::pd_state_t state,
    input logic                   request_new_inst
);

    // slot reservation for the in-flight entry keeps this bounded
    count_in_range: assert property (@(posedge clk) disable iff (rst)
        count <= rv32i_types::qcount_t'(rv32i_types::QUEUE_DEPTH))
        else $error("queue count above depth");

    no_fetch_in_jalr_wait: assert property (@(posedge clk) disable iff (rst)
        (state == rv32i_types::PD_JALR_WAIT) |-> !request_new_inst)
        else $error("fetch request while waiting for jalr target");

    empty_after_clear: assert property (@(posedge clk) disable iff (rst)
        clear |=> !out_valid)
        else $error("queue output valid right after clear");

endmodule

// queue side, fsm ports tied off
bind inst_queue fetch_props queue_props
(
    .clk              (clk),
    .rst              (rst),
    .count            (count),
    .clear            (clear),
    .out_valid        (out_valid),
    .state            (rv32i_types::PD_RUN),
    .request_new_inst (1'b0)
);

bind predecode fetch_props pd_props
(
    .clk              (clk),
    .rst              (rst),
    .count            ('0),
    .clear            (1'b0),
    .out_valid        (1'b0),
    .state            (state),
    .request_new_inst (request_new_inst)
);

// ==== dv/fetch_tb.sv ====
`timescale 1ns/1ns

module fetch_tb;

    localparam int RUN_CYCLES  = 4000;
    localparam int IDLE_LIMIT  = 64;    // cycles with no entry while one is due
    localparam int FIRST_LIMIT = 10;

    localparam logic [1:0] KIND_ALU  = 2'd0;
    localparam logic [1:0] KIND_JAL  = 2'd1;
    localparam logic [1:0] KIND_JALR = 2'd2;

    logic                    clk;
    logic                    rst;
    logic                    br_en;
    logic                    flush;
    logic                    branch_recovery;
    logic                    jalr_done;
    logic                    deq;
    logic                    imem_we;
    rv32i_types::addr_t      pc_branch;
    rv32i_types::addr_t      missed_pc;
    rv32i_types::addr_t      brr_pc;
    rv32i_types::addr_t      jalr_pc;
    rv32i_types::imem_addr_t imem_waddr;
    rv32i_types::word_t      imem_wdata;
    logic                    out_valid;
    rv32i_types::addr_t      out_pc;
    rv32i_types::word_t      out_inst;

    // memory copy and what each word does to the pc
    rv32i_types::word_t imem    [rv32i_types::IMEM_DEPTH];
    logic [1:0]         kind    [rv32i_types::IMEM_DEPTH];
    rv32i_types::addr_t jal_off [rv32i_types::IMEM_DEPTH];

    logic [31:0]        seed;
    rv32i_types::addr_t exp_pc;
    logic               exp_none;       // jalr consumed, target still unknown
    int                 jalr_wait;
    int                 pause;
    int                 idle;
    logic               redirect_now;
    rv32i_types::addr_t redirect_target;
    logic               timed_out;
    int                 checked;
    int                 redirects;
    int                 mismatches;
    int                 proto_errors;
    int                 timeouts;

    fetch_top uut
    (
        .clk             (clk),
        .rst             (rst),
        .br_en           (br_en),
        .flush           (flush),
        .branch_recovery (branch_recovery),
        .jalr_done       (jalr_done),
        .deq             (deq),
        .imem_we         (imem_we),
        .pc_branch       (pc_branch),
        .missed_pc       (missed_pc),
        .brr_pc          (brr_pc),
        .jalr_pc         (jalr_pc),
        .imem_waddr      (imem_waddr),
        .imem_wdata      (imem_wdata),
        .out_valid       (out_valid),
        .out_pc          (out_pc),
        .out_inst        (out_inst)
    );

    always #5 clk = ~clk;

    // two lcg steps, upper halves only
    function automatic logic [31:0] next_random();
        logic [15:0] hi;
        seed = seed * 32'd1664525 + 32'd1013904223;
        hi   = seed[31:16];
        seed = seed * 32'd1664525 + 32'd1013904223;
        return {hi, seed[31:16]};
    endfunction

    function automatic rv32i_types::addr_t random_target();
        logic [31:0] r;
        r = next_random();
        return {r[31:2], 2'b00};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("Fail at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            mismatches++;
        end
    endtask

    // 80% alu, 12% short jal, 8% jalr
    task automatic build_image();
        logic [31:0] r;
        logic [31:0] f;
        logic [31:0] off;
        int          i;
        for (i = 0; i < rv32i_types::IMEM_DEPTH; i++)
        begin
            r = next_random();
            f = next_random();
            if (r % 32'd100 < 32'd80)
            begin
                kind[i]    = KIND_ALU;
                jal_off[i] = '0;
                imem[i]    = {f[31:7], 7'b0010011};
            end
            else if (r % 32'd100 < 32'd92)
            begin
                off = {26'd0, f[3:0], 2'b00} + 32'd4;   // 1 to 16 words
                if (f[4])
                    off = 32'd0 - off;
                kind[i]    = KIND_JAL;
                jal_off[i] = off;
                imem[i]    = {off[20], off[10:1], off[11], off[19:12], f[11:7],
                              rv32i_types::OPC_JAL};
            end
            else
            begin
                kind[i]    = KIND_JALR;
                jal_off[i] = '0;
                imem[i]    = {f[31:15], 3'b000, f[11:7], rv32i_types::OPC_JALR};
            end
        end
    endtask

    task automatic load_memory();
        int i;
        for (i = 0; i < rv32i_types::IMEM_DEPTH; i++)
        begin
            @(posedge clk);
            #1;
            imem_we    = 1'b1;
            imem_waddr = rv32i_types::imem_addr_t'(i);
            imem_wdata = imem[i];
        end
        @(posedge clk);
        #1;
        imem_we = 1'b0;
    endtask

    task automatic wait_first_entry();
        int n;
        n = 0;
        while (!out_valid && n < FIRST_LIMIT)
        begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!out_valid)
        begin
            $display("timeout: no entry reached the queue output after reset");
            timeouts++;
            timed_out = 1'b1;
        end
    endtask

    // head entry leaves at the coming edge
    task automatic consume_entry();
        rv32i_types::imem_addr_t idx;
        logic [31:0]             r;
        if (exp_none)
        begin
            $display("Error at %0t ns: entry at pc %h came out before jalr_done", $time, out_pc);
            proto_errors++;
        end
        else
        begin
            idx = exp_pc[9:2];
            check_value("out_pc", exp_pc, out_pc);
            check_value("out_inst", imem[idx], out_inst);
            checked++;
            case (kind[idx])
                KIND_JAL:
                    exp_pc = exp_pc + jal_off[idx];
                KIND_JALR:
                begin
                    exp_none  = 1'b1;
                    r         = next_random();
                    jalr_wait = int'(r[2:0]);
                end
                default:
                    exp_pc = exp_pc + 32'd4;
            endcase
        end
    endtask

    task automatic drive_cycle();
        logic [31:0] r;
        br_en           = 1'b0;
        flush           = 1'b0;
        branch_recovery = 1'b0;
        jalr_done       = 1'b0;
        redirect_now    = 1'b0;
        r = next_random();
        if (pause != 0)
        begin
            deq = 1'b0;
            pause--;
        end
        else
        begin
            deq = (r[1:0] != 2'b00);
            if (r[7:3] == 5'd0)
                pause = 4 + int'(r[11:8]);  // long backend stall
        end
        r = next_random();
        if (r[5:0] == 6'd0)
        begin
            br_en           = r[6];
            flush           = r[7];
            branch_recovery = r[8] | (r[8:6] == 3'b000);
            pc_branch       = random_target();
            missed_pc       = random_target();
            brr_pc          = random_target();
            redirect_now    = 1'b1;
            if (br_en)
                redirect_target = pc_branch;
            else if (flush)
                redirect_target = missed_pc;
            else
                redirect_target = brr_pc;
        end
        else if (exp_none)
        begin
            if (jalr_wait == 0)
            begin
                jalr_done = 1'b1;
                jalr_pc   = random_target();
            end
            else
                jalr_wait--;
        end
    endtask

    task automatic evaluate_cycle();
        if (out_valid && deq)
        begin
            consume_entry();
            idle = 0;
        end
        else if (!exp_none)
            idle++;
        if (redirect_now)
        begin
            exp_pc   = redirect_target;   // queued entries are dropped
            exp_none = 1'b0;
            idle     = 0;
            redirects++;
        end
        else if (jalr_done)
        begin
            exp_pc   = jalr_pc;
            exp_none = 1'b0;
            idle     = 0;
        end
    endtask

    task automatic finish_run();
        $display("%0d entries checked, %0d redirects: %0d mismatches, %0d protocol errors, %0d timeouts",
                 checked, redirects, mismatches, proto_errors, timeouts);
        if (mismatches == 0 && proto_errors == 0 && timeouts == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    endtask

    initial
    begin
        clk             = 1'b0;
        rst             = 1'b1;
        br_en           = 1'b0;
        flush           = 1'b0;
        branch_recovery = 1'b0;
        jalr_done       = 1'b0;
        deq             = 1'b0;
        imem_we         = 1'b0;
        pc_branch       = '0;
        missed_pc       = '0;
        brr_pc          = '0;
        jalr_pc         = '0;
        imem_waddr      = '0;
        imem_wdata      = '0;
        seed            = 32'hd729_4b95;
        exp_pc          = rv32i_types::RESET_PC;
        exp_none        = 1'b0;
        jalr_wait       = 0;
        pause           = 0;
        idle            = 0;
        redirect_now    = 1'b0;
        redirect_target = '0;
        timed_out       = 1'b0;
        checked         = 0;
        redirects       = 0;
        mismatches      = 0;
        proto_errors    = 0;
        timeouts        = 0;

        build_image();
        load_memory();     // DUT sits in reset meanwhile
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        wait_first_entry();
        for (int cyc = 0; cyc < RUN_CYCLES && !timed_out; cyc++)
        begin
            drive_cycle();
            #4;            // mid cycle, outputs settled
            evaluate_cycle();
            if (idle > IDLE_LIMIT)
            begin
                $display("timeout: no entry left the queue for %0d cycles", IDLE_LIMIT);
                timeouts++;
                timed_out = 1'b1;
            end
            @(posedge clk);
            #1;
        end
        finish_run();
    end

endmodule

// ==== filelist.f ====
hdl/rv32i_types.sv
hdl/fetch_if.sv
hdl/pc_reg.sv
hdl/fetch_mem.sv
hdl/predecode.sv
hdl/inst_queue.sv
hdl/fetch_top.sv
dv/fetch_props.sv
dv/fetch_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the fetch frontend testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module fetch_tb -f filelist.f -Mdir obj_dir -o fetch_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/fetch_sim)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Test completed successfully"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1
